/* bench/eeprom_model.sv */
`timescale 1ns/1ns

module eeprom_model
(
    input  logic CLK,
    input  logic RESET,
    input  logic present,          // low: never acknowledge
    input  logic scl,
    input  logic sda,
    output logic sda_drive_low,
    output int   proto_errors
);
    localparam logic [3:0] DEV_CODE = 4'b1010;

    logic [7:0] mem [0:2047];
    logic [7:0] shreg;
    logic [7:0] tx;                // byte being sent on a read
    logic [7:0] word;
    logic [7:0] rbyte;
    logic [2:0] blk;
    logic [3:0] cnt;               // bits completed in the current 9-bit slot
    logic [1:0] byte_idx;
    logic scl_q;
    logic sda_q;
    logic bit_s;
    logic pending;                 // rising edge seen, bit not yet committed
    logic in_frame;
    logic selected;
    logic sending;
    logic load_read;

    assign rbyte = {shreg[6:0], bit_s};

    initial
    begin
        for (int a = 0; a < 2048; a++)
            mem[a] = 8'hFF;        // erased
    end

    always @(posedge CLK)
    begin
        logic ack;
        if (RESET)
        begin
            scl_q <= 1'b1;
            sda_q <= 1'b1;
            pending <= 1'b0;
            in_frame <= 1'b0;
            selected <= 1'b0;
            sending <= 1'b0;
            load_read <= 1'b0;
            cnt <= 4'd0;
            byte_idx <= 2'd0;
            sda_drive_low <= 1'b0;
            proto_errors <= 0;
        end
        else
        begin
            scl_q <= scl;
            sda_q <= sda;
            if (scl_q && scl && sda_q != sda)
            begin
                // a start or a stop, only legal between bytes
                if (cnt != 4'd0)
                begin
                    proto_errors <= proto_errors + 1;
                    $display("protocol error: SDA changed while SCL was high inside a byte");
                end
                in_frame <= sda_q;  // falling sda opens a frame
                pending <= 1'b0;
                cnt <= 4'd0;
                byte_idx <= 2'd0;
                sending <= 1'b0;
                load_read <= 1'b0;
                sda_drive_low <= 1'b0;
            end
            else if (!scl_q && scl)
            begin
                bit_s <= sda;
                pending <= in_frame;
            end
            else if (scl_q && !scl && pending)
            begin
                pending <= 1'b0;
                shreg <= rbyte;
                if (cnt == 4'd8)
                begin
                    // ack slot over
                    cnt <= 4'd0;
                    sending <= load_read;
                    load_read <= 1'b0;
                    tx <= mem[{blk, word}];
                    sda_drive_low <= load_read && !mem[{blk, word}][7];
                end
                else
                begin
                    cnt <= cnt + 4'd1;
                    if (sending)
                    begin
                        sda_drive_low <= (cnt == 4'd7) ? 1'b0 : !tx[6];
                        tx <= {tx[6:0], 1'b1};
                    end
                    else if (cnt == 4'd7)
                    begin
                        ack = (byte_idx == 2'd0) ? present && rbyte[7:4] == DEV_CODE
                                                 : present && selected;
                        case (byte_idx)
                            2'd0:
                            begin
                                selected <= ack;
                                blk <= rbyte[3:1];
                                load_read <= ack && rbyte[0];
                            end
                            2'd1: if (ack) word <= rbyte;
                            default: if (ack) mem[{blk, word}] <= rbyte;
                        endcase
                        sda_drive_low <= ack;
                        if (byte_idx != 2'd3)
                            byte_idx <= byte_idx + 2'd1;
                    end
                end
            end
        end
    end

endmodule

/* bench/tb_eeprom_if.sv */
`timescale 1ns/1ns
`include "eeprom_cfg.svh"

module tb_eeprom_if;
    import eeprom_pkg::*;

    typedef struct packed {
        logic     is_read;
        ee_addr_t addr;
        ee_byte_t wdata;
        logic     present;
        logic     intrude;      // second request pulse while busy
        ee_byte_t exp_rdata;
        logic     exp_nack;
    } test_row_t;

    logic CLK;
    logic RESET;
    logic req_valid;
    ee_req_t req;
    logic busy;
    logic done;
    ee_rsp_t rsp;
    logic scl;
    logic sda_drive_low;
    logic model_drive_low;
    logic present;
    wire sda;
    int proto_errors;

    string names[$];
    test_row_t rows[$];
    logic [7:0] ref_mem [0:2047];
    int mismatches = 0;
    int other_errors = 0;
    bit table_ready = 0;

    // open-drain line with pull-up
    assign sda = ~(sda_drive_low | model_drive_low);

    eeprom_if_top i_eeprom_if_top
    (
        .CLK           (CLK),
        .RESET         (RESET),
        .req_valid     (req_valid),
        .req           (req),
        .busy          (busy),
        .done          (done),
        .rsp           (rsp),
        .scl           (scl),
        .sda_drive_low (sda_drive_low),
        .sda_in        (sda)
    );

    eeprom_model i_eeprom_model
    (
        .CLK           (CLK),
        .RESET         (RESET),
        .present       (present),
        .scl           (scl),
        .sda           (sda),
        .sda_drive_low (model_drive_low),
        .proto_errors  (proto_errors)
    );

    initial
    begin
        CLK = 1'b0;
        forever #50 CLK = ~CLK;
    end

    task add_row(input string name, input logic is_read, input ee_addr_t addr,
                 input ee_byte_t wdata, input logic present_flag, input logic intrude,
                 input ee_byte_t exp_rdata, input logic exp_nack);
        test_row_t row;
        row = '{is_read, addr, wdata, present_flag, intrude, exp_rdata, exp_nack};
        names.push_back(name);
        rows.push_back(row);
    endtask

    task build_table;
        add_row("write_blk0", 1'b0, 11'h000, 8'hA5, 1'b1, 1'b0, 8'h00, 1'b0);
        add_row("write_blk1", 1'b0, 11'h155, 8'h3C, 1'b1, 1'b0, 8'h00, 1'b0);
        add_row("write_blk2", 1'b0, 11'h2AA, 8'hC3, 1'b1, 1'b0, 8'h00, 1'b0);
        add_row("write_blk7", 1'b0, 11'h7FF, 8'h5A, 1'b1, 1'b0, 8'h00, 1'b0);
        add_row("read_blk0", 1'b1, 11'h000, 8'h00, 1'b1, 1'b0, 8'hA5, 1'b0);
        add_row("read_blk1", 1'b1, 11'h155, 8'h00, 1'b1, 1'b0, 8'h3C, 1'b0);
        add_row("read_blk2", 1'b1, 11'h2AA, 8'h00, 1'b1, 1'b0, 8'hC3, 1'b0);
        add_row("read_blk7", 1'b1, 11'h7FF, 8'h00, 1'b1, 1'b0, 8'h5A, 1'b0);
        add_row("read_same_word_blk0", 1'b1, 11'h0AA, 8'h00, 1'b1, 1'b0, 8'hFF, 1'b0);
        add_row("overwrite", 1'b0, 11'h155, 8'h99, 1'b1, 1'b0, 8'h00, 1'b0);
        add_row("read_overwrite", 1'b1, 11'h155, 8'h00, 1'b1, 1'b0, 8'h99, 1'b0);
        add_row("read_erased", 1'b1, 11'h3E1, 8'h00, 1'b1, 1'b0, 8'hFF, 1'b0);
        add_row("write_absent", 1'b0, 11'h123, 8'h77, 1'b0, 1'b0, 8'h00, 1'b1);
        add_row("read_absent", 1'b1, 11'h123, 8'h00, 1'b0, 1'b0, 8'h00, 1'b1);
        add_row("read_recovered", 1'b1, 11'h123, 8'h00, 1'b1, 1'b0, 8'hFF, 1'b0);
        add_row("write_busy_pulse", 1'b0, 11'h0F0, 8'hE1, 1'b1, 1'b1, 8'h00, 1'b0);
        add_row("read_busy_pulse", 1'b1, 11'h0F0, 8'h00, 1'b1, 1'b1, 8'hE1, 1'b0);
        add_row("read_pulse_ignored", 1'b1, 11'h0F1, 8'h00, 1'b1, 1'b0, 8'hFF, 1'b0);
    endtask

    task report_counts;
        $display("errors: %0d mismatches, %0d other, %0d protocol",
                 mismatches, other_errors, proto_errors);
    endtask

    task wait_done;
        @(negedge CLK);
        while (!done)
            @(negedge CLK);
    endtask

    task run_row(input int i);
        test_row_t row;
        row = rows[i];
        if (row.is_read && !row.exp_nack && ref_mem[row.addr] !== row.exp_rdata)
        begin
            other_errors++;
            $display("%s expects %h but the reference memory holds %h",
                     names[i], row.exp_rdata, ref_mem[row.addr]);
        end
        @(posedge CLK);
        present <= row.present;
        req_valid <= 1'b1;
        req <= {row.is_read, row.addr, row.wdata};
        @(posedge CLK);
        req_valid <= 1'b0;
        @(negedge CLK);
        if (busy !== 1'b1)
        begin
            other_errors++;
            $display("%s: busy did not rise the cycle after the request", names[i]);
        end
        if (row.intrude)
        begin
            repeat (3) @(posedge CLK);
            @(negedge CLK);
            if (!busy)
            begin
                other_errors++;
                $display("%s: busy was low when the extra request was sent", names[i]);
            end
            @(posedge CLK);
            req_valid <= 1'b1;
            req <= {1'b0, row.addr ^ 11'h001, ~row.wdata};   // must be dropped
            @(posedge CLK);
            req_valid <= 1'b0;
        end
        wait_done;
        if (busy)
        begin
            other_errors++;
            $display("%s: busy still high in the done cycle", names[i]);
        end
        if (rsp.nack !== row.exp_nack)
        begin
            mismatches++;
            $display("Mismatch %s nack: expected %0b, actual %0b",
                     names[i], row.exp_nack, rsp.nack);
        end
        if (row.is_read && !row.exp_nack && rsp.rdata !== row.exp_rdata)
        begin
            mismatches++;
            $display("Mismatch %s rdata: expected %h, actual %h",
                     names[i], row.exp_rdata, rsp.rdata);
        end
        if (scl !== 1'b1 || sda !== 1'b1)
        begin
            other_errors++;
            $display("%s: bus not released after the transfer", names[i]);
        end
        @(negedge CLK);
        if (done !== 1'b0)
        begin
            other_errors++;
            $display("%s: done stayed high for more than one cycle", names[i]);
        end
        if (!row.is_read && !row.exp_nack)
            ref_mem[row.addr] = row.wdata;
    endtask

    initial
    begin
        RESET = 1'b1;
        req_valid = 1'b0;
        req = '0;
        present = 1'b1;
        for (int a = 0; a < 2048; a++)
            ref_mem[a] = 8'hFF;
        build_table();
        table_ready = 1'b1;
        repeat (2) @(posedge CLK);
        RESET <= 1'b0;
        @(negedge CLK);
        if (busy !== 1'b0 || done !== 1'b0 || scl !== 1'b1 || sda_drive_low !== 1'b0)
        begin
            other_errors++;
            $display("outputs not at rest after reset");
        end
        for (int i = 0; i < rows.size(); i++)
            run_row(i);
        repeat (4) @(negedge CLK);
        report_counts();
        if (mismatches + other_errors + proto_errors == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

    // one read is about 160 quarter periods, 200 leaves room for handoffs
    initial
    begin
        int limit;
        int cycles;
        wait (table_ready);
        limit = rows.size() * 200 * `EE_QTR_CYC + 100;
        cycles = 0;
        while (cycles < limit)
        begin
            @(posedge CLK);
            cycles++;
        end
        other_errors++;
        $display("timeout after %0d cycles, a transfer never finished", limit);
        report_counts();
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

/* include/eeprom_cfg.svh */
`ifndef EEPROM_CFG_SVH
`define EEPROM_CFG_SVH

// fixed upper nibble of the 24C16 control byte
`define EE_DEV_CODE 4'b1010

// 2 KB array, 11 address bits
`define EE_ADDR_W 11

// block select bits carried in the control byte
`define EE_BLK_W 3

`define EE_BYTE_W 8

// CLK cycles per quarter SCL period
// one bit on the bus takes 4 x this value, must be 1 or more
`define EE_QTR_CYC 2

// low part of the address sent as the word address byte
`define EE_WORD_W (`EE_ADDR_W - `EE_BLK_W)

`endif

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module tb_eeprom_if

if ! ./obj_dir/Vtb_eeprom_if > sim.log 2>&1; then
    cat sim.log
    echo "simulator exited with an error"
    exit 1
fi
cat sim.log

if grep -q "Simulation finished: FAIL" sim.log; then
    exit 1
fi
grep -q "Simulation finished: PASS" sim.log

/* src/eeprom_ctrl.sv */
`timescale 1ns/1ns
`include "eeprom_cfg.svh"

module eeprom_ctrl
(
    input  logic                 CLK,
    input  logic                 RESET,
    input  logic                 req_valid,
    input  eeprom_pkg::ee_req_t  req,
    output logic                 busy,
    output logic                 done,
    output eeprom_pkg::ee_rsp_t  rsp,
    output logic                 cmd_valid,
    output eeprom_pkg::i2c_cmd_t cmd,
    input  logic                 cmd_ready,
    input  logic                 cmd_done,
    input  logic                 ack_seen,
    input  eeprom_pkg::ee_byte_t rx
);
    import eeprom_pkg::*;

    ctrl_state_e state;
    ee_req_t req_q;
    ee_byte_t rdata_q;
    i2c_cmd_t next_cmd;
    logic nack_q;
    logic pending;       // command issued, waiting for cmd_done
    logic accept;
    logic active;
    logic issue;
    logic [`EE_BLK_W-1:0] blk;

    assign accept = (state == S_IDLE) && req_valid;
    assign active = (state != S_IDLE) && (state != S_FINISH);
    assign issue = active && !pending && cmd_ready;
    assign blk = req_q.addr[`EE_ADDR_W-1:`EE_WORD_W];

    always_comb
    begin
        next_cmd.op = CMD_STOP;
        next_cmd.tx = '0;
        next_cmd.last = 1'b0;
        case (state)
            S_START, S_RESTART: next_cmd.op = CMD_START;
            S_CTRL_W:
            begin
                next_cmd.op = CMD_WRITE;
                next_cmd.tx = {`EE_DEV_CODE, blk, 1'b0};
            end
            S_ADDR:
            begin
                next_cmd.op = CMD_WRITE;
                next_cmd.tx = req_q.addr[`EE_WORD_W-1:0];
            end
            S_DATA:
            begin
                next_cmd.op = CMD_WRITE;
                next_cmd.tx = req_q.wdata;
            end
            S_CTRL_R:
            begin
                next_cmd.op = CMD_WRITE;
                next_cmd.tx = {`EE_DEV_CODE, blk, 1'b1};
            end
            S_READ:
            begin
                next_cmd.op = CMD_READ;
                next_cmd.last = 1'b1;      // single byte, end with NACK
            end
            default: ;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state <= S_IDLE;
            busy <= 1'b0;
            done <= 1'b0;
            cmd_valid <= 1'b0;
            pending <= 1'b0;
            nack_q <= 1'b0;
        end
        else
        begin
            done <= 1'b0;
            cmd_valid <= issue;
            if (issue)
                pending <= 1'b1;
            if (cmd_done)
                pending <= 1'b0;
            case (state)
                S_IDLE:
                begin
                    if (accept)
                    begin
                        busy <= 1'b1;
                        nack_q <= 1'b0;
                        state <= S_START;
                    end
                end
                S_START:   if (cmd_done) state <= S_CTRL_W;
                S_RESTART: if (cmd_done) state <= S_CTRL_R;
                S_CTRL_W, S_ADDR, S_CTRL_R:
                begin
                    if (cmd_done)
                    begin
                        if (!ack_seen)
                        begin
                            nack_q <= 1'b1;
                            state <= S_STOP;       // give up, release the bus
                        end
                        else if (state == S_CTRL_R)
                            state <= S_READ;
                        else if (state == S_CTRL_W)
                            state <= S_ADDR;
                        else
                            state <= req_q.is_read ? S_RESTART : S_DATA;
                    end
                end
                S_DATA:
                begin
                    if (cmd_done)
                    begin
                        nack_q <= !ack_seen;
                        state <= S_STOP;
                    end
                end
                S_READ:    if (cmd_done) state <= S_STOP;
                S_STOP:    if (cmd_done) state <= S_FINISH;
                default:
                begin
                    busy <= 1'b0;
                    done <= 1'b1;
                    state <= S_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge CLK)
    begin
        if (accept)
        begin
            req_q <= req;
            rdata_q <= '0;                 // writes report zero
        end
        else if (state == S_READ && cmd_done)
            rdata_q <= rx;
        if (issue)
            cmd <= next_cmd;
        if (state == S_FINISH)
        begin
            rsp.rdata <= rdata_q;
            rsp.nack <= nack_q;
        end
    end

    a_cmd_handshake: assert property (@(posedge CLK) disable iff (RESET)
        cmd_valid |-> cmd_ready)
        else $error("command issued while the bit engine is busy");

    a_req_hold: assert property (@(posedge CLK) disable iff (RESET)
        req_valid && busy |=> $stable(req_q))
        else $error("request latched while busy");

endmodule

/* src/eeprom_if_top.sv */
`timescale 1ns/1ns

module eeprom_if_top
(
    input  logic                CLK,
    input  logic                RESET,
    input  logic                req_valid,
    input  eeprom_pkg::ee_req_t req,
    output logic                busy,
    output logic                done,
    output eeprom_pkg::ee_rsp_t rsp,
    output logic                scl,
    output logic                sda_drive_low,
    input  logic                sda_in
);
    import eeprom_pkg::*;

    // sequencer to bit engine
    i2c_cmd_t cmd;
    ee_byte_t rx;
    logic cmd_valid;
    logic cmd_ready;
    logic cmd_done;
    logic ack_seen;

    eeprom_ctrl i_eeprom_ctrl
    (
        .CLK       (CLK),
        .RESET     (RESET),
        .req_valid (req_valid),
        .req       (req),
        .busy      (busy),
        .done      (done),
        .rsp       (rsp),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .cmd_ready (cmd_ready),
        .cmd_done  (cmd_done),
        .ack_seen  (ack_seen),
        .rx        (rx)
    );

    i2c_bit_engine i_i2c_bit_engine
    (
        .CLK           (CLK),
        .RESET         (RESET),
        .cmd_valid     (cmd_valid),
        .cmd           (cmd),
        .cmd_ready     (cmd_ready),
        .cmd_done      (cmd_done),
        .ack_seen      (ack_seen),
        .rx            (rx),
        .scl           (scl),
        .sda_drive_low (sda_drive_low),
        .sda_in        (sda_in)
    );

endmodule

/* src/eeprom_pkg.sv */
`include "eeprom_cfg.svh"

package eeprom_pkg;

    typedef logic [`EE_ADDR_W-1:0] ee_addr_t;
    typedef logic [`EE_BYTE_W-1:0] ee_byte_t;

    // one bus primitive, CMD_START also gives the repeated start
    typedef enum logic [1:0] {CMD_START, CMD_STOP, CMD_WRITE, CMD_READ} i2c_cmd_e;

    typedef struct packed {
        logic     is_read;
        ee_addr_t addr;
        ee_byte_t wdata;
    } ee_req_t;

    typedef struct packed {
        ee_byte_t rdata;
        logic     nack;     // an expected ACK was missing
    } ee_rsp_t;

    typedef struct packed {
        i2c_cmd_e op;
        ee_byte_t tx;
        logic     last;     // NACK after the read byte
    } i2c_cmd_t;

    typedef enum logic [3:0] {
        S_IDLE, S_START, S_CTRL_W, S_ADDR, S_DATA,
        S_RESTART, S_CTRL_R, S_READ, S_STOP, S_FINISH
    } ctrl_state_e;

    typedef enum logic [2:0] {B_IDLE, B_START, B_WRITE, B_READ, B_STOP} bit_state_e;

endpackage

/* src/i2c_bit_engine.sv */
`timescale 1ns/1ns
`include "eeprom_cfg.svh"

module i2c_bit_engine
(
    input  logic                 CLK,
    input  logic                 RESET,
    input  logic                 cmd_valid,
    input  eeprom_pkg::i2c_cmd_t cmd,
    output logic                 cmd_ready,
    output logic                 cmd_done,
    output logic                 ack_seen,
    output eeprom_pkg::ee_byte_t rx,
    output logic                 scl,
    output logic                 sda_drive_low,
    input  logic                 sda_in
);
    import eeprom_pkg::*;

    localparam int QW = ($clog2(`EE_QTR_CYC) > 0) ? $clog2(`EE_QTR_CYC) : 1;
    localparam logic [QW-1:0] QMAX = QW'(`EE_QTR_CYC - 1);
    localparam logic [3:0] BYTE_LAST = 4'(`EE_BYTE_W);   // ACK slot index

    bit_state_e state;
    bit_state_e op_state;

    logic [QW-1:0] qcnt;
    logic [1:0] phase;
    logic [1:0] nxt_phase;
    logic [3:0] bitcnt;
    logic [3:0] last_bit;
    logic [`EE_BYTE_W:0] sh;     // MSB is the level for the next bit, 1 = release
    logic accept;
    logic tick;
    logic finish;

    assign cmd_ready = (state == B_IDLE);
    assign accept = cmd_valid && cmd_ready;
    assign tick = (state != B_IDLE) && (qcnt == QMAX);
    assign nxt_phase = phase + 2'd1;
    assign last_bit = (state == B_WRITE || state == B_READ) ? BYTE_LAST : 4'd0;
    assign finish = tick && (phase == 2'd3) && (bitcnt == last_bit);

    always_comb
    begin
        case (cmd.op)
            CMD_START: op_state = B_START;
            CMD_STOP:  op_state = B_STOP;
            CMD_WRITE: op_state = B_WRITE;
            default:   op_state = B_READ;
        endcase
    end

    // phases per bit: 0 scl low + sda set, 1 scl high, 2 sample, 3 scl low
    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state <= B_IDLE;
            qcnt <= '0;
            phase <= 2'd0;
            bitcnt <= 4'd0;
            cmd_done <= 1'b0;
            scl <= 1'b1;              // bus at rest
            sda_drive_low <= 1'b0;
        end
        else
        begin
            cmd_done <= 1'b0;
            if (accept)
            begin
                state <= op_state;
                qcnt <= QMAX;         // first boundary on the next cycle
                phase <= 2'd3;
                bitcnt <= 4'hF;
            end
            else if (state != B_IDLE)
            begin
                qcnt <= tick ? '0 : qcnt + 1'b1;
                if (finish)
                begin
                    state <= B_IDLE;
                    cmd_done <= 1'b1;
                end
                else if (tick)
                begin
                    phase <= nxt_phase;
                    if (nxt_phase == 2'd0)
                        bitcnt <= bitcnt + 4'd1;
                    case (state)
                        B_START:
                        begin
                            case (nxt_phase)
                                2'd0:
                                begin
                                    scl <= 1'b0;
                                    sda_drive_low <= 1'b0;
                                end
                                2'd1: scl <= 1'b1;
                                2'd2: sda_drive_low <= 1'b1;   // falls with scl high
                                default: scl <= 1'b0;
                            endcase
                        end
                        B_STOP:
                        begin
                            case (nxt_phase)
                                2'd0:
                                begin
                                    scl <= 1'b0;
                                    sda_drive_low <= 1'b1;
                                end
                                2'd1: scl <= 1'b1;
                                2'd2: sda_drive_low <= 1'b0;   // rises with scl high
                                default: ;                     // rest with both high
                            endcase
                        end
                        B_WRITE, B_READ:
                        begin
                            case (nxt_phase)
                                2'd0:
                                begin
                                    scl <= 1'b0;
                                    sda_drive_low <= ~sh[`EE_BYTE_W];
                                end
                                2'd1: scl <= 1'b1;
                                2'd2: ;
                                default: scl <= 1'b0;
                            endcase
                        end
                        default: ;
                    endcase
                end
            end
        end
    end

    // shift and capture registers
    always_ff @(posedge CLK)
    begin
        if (accept)
        begin
            if (cmd.op == CMD_READ)
                sh <= {{`EE_BYTE_W{1'b1}}, cmd.last};   // release 8 bits, then ACK/NACK
            else
                sh <= {cmd.tx, 1'b1};                   // data, then release for ACK
        end
        else if (tick && nxt_phase == 2'd0)
            sh <= {sh[`EE_BYTE_W-1:0], 1'b1};

        if (tick && nxt_phase == 2'd2)
        begin
            if (state == B_READ && bitcnt < BYTE_LAST)
                rx <= {rx[`EE_BYTE_W-2:0], sda_in};
            if (state == B_WRITE && bitcnt == BYTE_LAST)
                ack_seen <= ~sda_in;
        end
    end

    // data may only move while scl is low, start and stop excepted
    a_sda_stable: assert property (@(posedge CLK) disable iff (RESET)
        (sda_drive_low != $past(sda_drive_low)) && state != B_START && state != B_STOP
        |-> !scl && !$past(scl))
        else $error("sda drive changed while scl high");

endmodule

/* verilog.f */
+incdir+include
src/eeprom_pkg.sv
src/i2c_bit_engine.sv
src/eeprom_ctrl.sv
src/eeprom_if_top.sv
bench/eeprom_model.sv
bench/tb_eeprom_if.sv
